// ==== rtl/fifo_pkg.sv ====
// Shared widths, depth and register map for the Wishbone byte FIFO
`default_nettype none

package fifo_pkg;

    // FIFO core geometry
    localparam int data_w  = 8;
    localparam int depth   = 16;
    localparam int ptr_w   = 4;
    // Fill count has to reach depth itself
    localparam int count_w = 5;

    // Wishbone side
    localparam int wb_dw = 32;
    localparam int wb_aw = 4;

    // Register byte offsets
    localparam logic [wb_aw-1:0] reg_data    = 4'h0;
    localparam logic [wb_aw-1:0] reg_status  = 4'h4;
    localparam logic [wb_aw-1:0] reg_control = 4'h8;

    // Status register layout
    localparam int st_count_lsb = 0;
    localparam int st_full      = 8;
    localparam int st_empty     = 9;
    localparam int st_overflow  = 10;
    localparam int st_underflow = 11;

    // Control register layout, flush reads back as zero
    localparam int ctl_lock  = 0;
    localparam int ctl_flush = 1;

endpackage

`default_nettype wire

// ==== rtl/addr_gen.sv ====
// Wrapping FIFO pointer with enable and synchronous clear
`default_nettype none

module addr_gen (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      en,
    input  wire logic                      clear,
    output logic      [fifo_pkg::ptr_w-1:0] addr
);
    import fifo_pkg::*;

    // Last valid slot before wrapping back to zero
    localparam logic [ptr_w-1:0] last_addr = ptr_w'(depth - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr <= '0;
        end else if (clear) begin
            addr <= '0;
        end else if (en) begin
            if (addr == last_addr) begin
                addr <= '0;
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fifo.sv ====
// Byte FIFO core with drop-on-full, lock and flush handling
`default_nettype none

module fifo (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        push,
    input  wire logic                        pop,
    input  wire logic                        flush,
    input  wire logic                        lock,
    input  wire logic [fifo_pkg::data_w-1:0] wdata,
    output logic      [fifo_pkg::data_w-1:0] rdata,
    output logic      [fifo_pkg::count_w-1:0] count,
    output logic                             full,
    output logic                             empty
);
    import fifo_pkg::*;

    localparam logic [count_w-1:0] count_max = count_w'(depth);

    logic [data_w-1:0] mem [depth];

    logic [ptr_w-1:0] wr_addr;
    logic [ptr_w-1:0] rd_addr;

    logic push_ok;
    logic pop_ok;

    // Pushes into a full FIFO are dropped
    assign push_ok = push && !full;

    // Pops need data and an unlocked FIFO
    assign pop_ok = pop && !empty && !lock;

    addr_gen write_ptr (
        .clk   (clk),
        .rst   (rst),
        .en    (push_ok),
        .clear (flush),
        .addr  (wr_addr)
    );

    addr_gen read_ptr (
        .clk   (clk),
        .rst   (rst),
        .en    (pop_ok),
        .clear (flush),
        .addr  (rd_addr)
    );

    // Storage, sync write
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_addr] <= wdata;
        end
    end

    // Async read, zero while locked or nothing held
    assign rdata = (lock || empty) ? '0 : mem[rd_addr];

    // Fill count
    // Simultaneous push and pop leave it unchanged
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else if (push_ok && !pop_ok) begin
            count <= count + 1'b1;
        end else if (pop_ok && !push_ok) begin
            count <= count - 1'b1;
        end
    end

    assign full  = (count == count_max);
    assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== rtl/fifo_wb_regs.sv ====
// Wishbone classic register slave for the byte FIFO with sticky error flags
`default_nettype none

module fifo_wb_regs (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         cyc,
    input  wire logic                         stb,
    input  wire logic                         we,
    input  wire logic [fifo_pkg::wb_aw-1:0]   adr,
    input  wire logic [fifo_pkg::wb_dw-1:0]   dat_w,
    output logic                              ack,
    output logic      [fifo_pkg::wb_dw-1:0]   dat_r,
    output logic                              push,
    output logic                              pop,
    output logic                              flush,
    output logic                              lock,
    output logic      [fifo_pkg::data_w-1:0]  wdata,
    input  wire logic [fifo_pkg::data_w-1:0]  rdata,
    input  wire logic [fifo_pkg::count_w-1:0] count,
    input  wire logic                         full,
    input  wire logic                         empty
);
    import fifo_pkg::*;

    logic req;
    logic sel_data;
    logic sel_status;
    logic sel_control;

    logic data_wr;
    logic data_rd;
    logic status_wr;
    logic control_wr;

    logic overflow;
    logic underflow;

    logic [wb_dw-1:0] status_word;
    logic [wb_dw-1:0] control_word;
    logic [wb_dw-1:0] rd_mux;

    // New request only while ack is low, one access per handshake
    assign req = cyc && stb && !ack;

    assign sel_data    = (adr == reg_data);
    assign sel_status  = (adr == reg_status);
    assign sel_control = (adr == reg_control);

    assign data_wr    = req && we && sel_data;
    assign data_rd    = req && !we && sel_data;
    assign status_wr  = req && we && sel_status;
    assign control_wr = req && we && sel_control;

    // Strobes to the core, active on the request edge
    assign push  = data_wr;
    assign pop   = data_rd;
    assign flush = control_wr && dat_w[ctl_flush];
    assign wdata = dat_w[data_w-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // Sticky flags, set by bad accesses, cleared by writing ones
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (data_wr && full) begin
                overflow <= 1'b1;
            end else if (status_wr && dat_w[st_overflow]) begin
                overflow <= 1'b0;
            end

            if (data_rd && (empty || lock)) begin
                underflow <= 1'b1;
            end else if (status_wr && dat_w[st_underflow]) begin
                underflow <= 1'b0;
            end
        end
    end

    // Lock level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lock <= 1'b0;
        end else if (control_wr) begin
            lock <= dat_w[ctl_lock];
        end
    end

    always_comb begin
        status_word = '0;
        status_word[st_count_lsb +: count_w] = count;
        status_word[st_full]      = full;
        status_word[st_empty]     = empty;
        status_word[st_overflow]  = overflow;
        status_word[st_underflow] = underflow;
    end

    always_comb begin
        control_word = '0;
        control_word[ctl_lock] = lock;
    end

    // Read mux, unmapped offsets give zero
    always_comb begin
        rd_mux = '0;
        if (sel_data) begin
            rd_mux = wb_dw'(rdata);
        end else if (sel_status) begin
            rd_mux = status_word;
        end else if (sel_control) begin
            rd_mux = control_word;
        end
    end

    // Captured on the request edge, before a pop moves the pointer
    always_ff @(posedge clk) begin
        if (req) begin
            dat_r <= we ? '0 : rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fifo_wb.sv ====
// Top level of the Wishbone byte FIFO, register slave plus FIFO core
`default_nettype none

module fifo_wb (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       cyc,
    input  wire logic                       stb,
    input  wire logic                       we,
    input  wire logic [fifo_pkg::wb_aw-1:0] adr,
    input  wire logic [fifo_pkg::wb_dw-1:0] dat_w,
    output logic                            ack,
    output logic      [fifo_pkg::wb_dw-1:0] dat_r
);
    import fifo_pkg::*;

    // Strobes and levels from the slave
    logic              push;
    logic              pop;
    logic              flush;
    logic              lock;
    logic [data_w-1:0] wdata;

    // Core state back to the slave
    logic [data_w-1:0]  rdata;
    logic [count_w-1:0] count;
    logic               full;
    logic               empty;

    fifo_wb_regs regs (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .ack   (ack),
        .dat_r (dat_r),
        .push  (push),
        .pop   (pop),
        .flush (flush),
        .lock  (lock),
        .wdata (wdata),
        .rdata (rdata),
        .count (count),
        .full  (full),
        .empty (empty)
    );

    fifo core (
        .clk   (clk),
        .rst   (rst),
        .push  (push),
        .pop   (pop),
        .flush (flush),
        .lock  (lock),
        .wdata (wdata),
        .rdata (rdata),
        .count (count),
        .full  (full),
        .empty (empty)
    );

endmodule

`default_nettype wire

// ==== test/fifo_wb_tb.sv ====
// Testbench for the Wishbone byte FIFO, a table of bus accesses checked against a queue model
`default_nettype none

module fifo_wb_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fifo_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 16;
    localparam int ack_limit    = 8;

    logic             clk;
    logic             rst;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [wb_aw-1:0] adr;
    logic [wb_dw-1:0] dat_w;
    logic             ack;
    logic [wb_dw-1:0] dat_r;

    // Stimulus table, one entry per bus access
    logic             op_q[$];
    logic [wb_aw-1:0] adr_q[$];
    logic [wb_dw-1:0] wdat_q[$];
    logic [wb_dw-1:0] exp_q[$];
    logic             cmp_q[$];
    logic             table_ready = 1'b0;

    // Reference model of the FIFO and its flags
    logic [data_w-1:0] model_q[$];
    logic              model_ovf;
    logic              model_unf;
    logic              model_lock;

    int errors = 0;

    fifo_wb UUT (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .ack   (ack),
        .dat_r (dat_r)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [wb_dw-1:0] status_word(input int cnt, input logic ovf,
                                                     input logic unf);
        logic [wb_dw-1:0] w;
        w = '0;
        w[st_count_lsb +: count_w] = count_w'(cnt);
        w[st_full]      = (cnt == depth);
        w[st_empty]     = (cnt == 0);
        w[st_overflow]  = ovf;
        w[st_underflow] = unf;
        return w;
    endfunction

    task automatic add_step(input logic write, input logic [wb_aw-1:0] addr,
                            input logic [wb_dw-1:0] wdata, input logic [wb_dw-1:0] expected,
                            input logic compare);
        op_q.push_back(write);
        adr_q.push_back(addr);
        wdat_q.push_back(wdata);
        exp_q.push_back(expected);
        cmp_q.push_back(compare);
    endtask

    task automatic push_byte(input logic [data_w-1:0] b);
        // A full FIFO drops the byte and flags overflow
        if (model_q.size() == depth) begin
            model_ovf = 1'b1;
        end else begin
            model_q.push_back(b);
        end
        add_step(1'b1, reg_data, wb_dw'(b), '0, 1'b0);
    endtask

    task automatic push_random(input int n);
        logic [data_w-1:0] b;
        for (int i = 0; i < n; i++) begin
            b = data_w'($urandom);
            push_byte(b);
        end
    endtask

    task automatic pop_byte();
        logic [data_w-1:0] b;
        if (model_q.size() == 0 || model_lock) begin
            b = '0;
            model_unf = 1'b1;
        end else begin
            b = model_q.pop_front();
        end
        add_step(1'b0, reg_data, '0, wb_dw'(b), 1'b1);
    endtask

    task automatic read_status();
        add_step(1'b0, reg_status, '0, status_word(model_q.size(), model_ovf, model_unf), 1'b1);
    endtask

    task automatic clear_flags(input logic ovf, input logic unf);
        logic [wb_dw-1:0] w;
        w = '0;
        w[st_overflow]  = ovf;
        w[st_underflow] = unf;
        if (ovf) begin
            model_ovf = 1'b0;
        end
        if (unf) begin
            model_unf = 1'b0;
        end
        add_step(1'b1, reg_status, w, '0, 1'b0);
    endtask

    task automatic write_control(input logic lock_bit, input logic flush_bit);
        logic [wb_dw-1:0] w;
        w = '0;
        w[ctl_lock]  = lock_bit;
        w[ctl_flush] = flush_bit;
        model_lock = lock_bit;
        if (flush_bit) begin
            model_q.delete();
        end
        add_step(1'b1, reg_control, w, '0, 1'b0);
    endtask

    task automatic read_control();
        logic [wb_dw-1:0] w;
        w = '0;
        w[ctl_lock] = model_lock;
        add_step(1'b0, reg_control, '0, w, 1'b1);
    endtask

    task automatic build_table();
        // State right after reset
        read_status();
        read_control();
        // Fill up, then one byte too many
        push_random(depth);
        read_status();
        push_random(1);
        read_status();
        clear_flags(1'b1, 1'b0);
        read_status();
        // Drain, bytes come back in write order
        for (int i = 0; i < depth; i++) begin
            pop_byte();
        end
        read_status();
        // Read from an empty FIFO
        pop_byte();
        read_status();
        clear_flags(1'b0, 1'b1);
        read_status();
        // Lock holds the byte back
        push_random(1);
        write_control(1'b1, 1'b0);
        read_control();
        pop_byte();
        read_status();
        write_control(1'b0, 1'b0);
        clear_flags(1'b0, 1'b1);
        pop_byte();
        read_status();
        // Flush part way, then reuse from the start
        push_random(5);
        read_status();
        write_control(1'b0, 1'b1);
        read_status();
        push_random(3);
        for (int i = 0; i < 3; i++) begin
            pop_byte();
        end
        read_status();
    endtask

    task automatic check(input string name, input logic [wb_dw-1:0] expected,
                         input logic [wb_dw-1:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic wb_access(input logic write, input logic [wb_aw-1:0] addr,
                             input logic [wb_dw-1:0] wdata, output logic [wb_dw-1:0] rdata,
                             output logic got_ack);
        int waited;
        got_ack = 1'b0;
        rdata = '0;
        waited = 0;
        @(posedge clk);
        #2;
        // Any earlier ack is a single cycle wide
        check("ack", '0, wb_dw'(ack));
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        // Ack is sampled just after the edge, once it has settled
        while (!got_ack && waited < ack_limit) begin
            @(posedge clk);
            #1;
            waited++;
            if (ack) begin
                got_ack = 1'b1;
                rdata = dat_r;
            end
        end
        if (!got_ack) begin
            $display("Bus access to offset 0x%0h got no ack within %0d cycles at %0t",
                     addr, ack_limit, $time);
            errors++;
        end else begin
            // One cycle from request edge to ack
            check("ack latency", wb_dw'(1), wb_dw'(waited));
        end
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    initial begin
        logic [wb_dw-1:0] rdata;
        logic             got_ack;
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        void'($urandom(14));
        model_ovf  = 1'b0;
        model_unf  = 1'b0;
        model_lock = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < op_q.size(); i++) begin
            wb_access(op_q[i], adr_q[i], wdat_q[i], rdata, got_ack);
            if (got_ack && cmp_q[i]) begin
                check($sformatf("dat_r step %0d", i), exp_q[i], rdata);
            end
        end

        $display("Run complete, %0d steps, %0d errors", op_q.size(), errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog, generous bound of ten cycles per table step
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = op_q.size() * 10 * clk_period + reset_cycles * clk_period;
        #(limit_ns);
        $display("Timeout, the test table did not finish within %0d ns", limit_ns);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== fifo_wb.f ====
rtl/fifo_pkg.sv
rtl/addr_gen.sv
rtl/fifo.sv
rtl/fifo_wb_regs.sv
rtl/fifo_wb.sv
test/fifo_wb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the Wishbone byte FIFO testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f fifo_wb.f --top-module fifo_wb_tb -o fifo_wb_sim

output=$(./obj_dir/fifo_wb_sim)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
